// ==== hw/bcd_pkg.sv ====
`default_nettype none

package bcd_pkg;

	// conversion widths
	localparam int bin_bits = 8;
	localparam int bcd_digits = 3;
	localparam int bcd_bits = 4 * bcd_digits;

	// index counters inside the converter
	localparam int bit_idx_bits = $clog2(bin_bits);
	localparam int digit_idx_bits = $clog2(bcd_digits);

	// display scan rate, cycles per digit
	localparam int scan_div = 4;
	localparam int scan_cnt_bits = $clog2(scan_div);

	// digit 0 sits in the low nibble
	typedef union packed {
		logic [bcd_bits-1:0] flat;
		logic [bcd_digits-1:0][3:0] digit;
	} bcd_word_t;

	// segments active high, bit order g f e d c b a
	localparam logic [9:0][6:0] seg_pattern = {
		7'h6F, 7'h7F, 7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F
	};

endpackage

`default_nettype wire

// ==== hw/apb_map_pkg.sv ====
`default_nettype none

package apb_map_pkg;

	localparam int apb_addr_bits = 4;
	localparam int apb_data_bits = 32;

	// register offsets
	localparam logic [apb_addr_bits-1:0] reg_number = 4'h0;
	localparam logic [apb_addr_bits-1:0] reg_ctrl = 4'h4;
	localparam logic [apb_addr_bits-1:0] reg_status = 4'h8;
	localparam logic [apb_addr_bits-1:0] reg_result = 4'hC;

	// bit positions
	localparam int ctrl_start_bit = 0;
	localparam int status_done_bit = 0;

endpackage

`default_nettype wire

// ==== hw/bcd_converter.sv ====
`timescale 1ns/10ps
`default_nettype none

// double dabble, one digit checked per add cycle
module bcd_converter
	import bcd_pkg::*;
(
	input wire logic in_clk,
	input wire logic in_rst,
	input wire logic start,
	input wire logic [bin_bits-1:0] number,
	output bcd_word_t bcd,
	output logic finished
);

	typedef enum logic [2:0] {
		st_idle,
		st_load,
		st_shift,
		st_add,
		st_next
	} state_t;

	state_t state, state_next;
	bcd_word_t bcd_next;
	logic [bit_idx_bits-1:0] bit_idx, bit_idx_next;
	logic [digit_idx_bits-1:0] digit_idx, digit_idx_next;

	assign finished = (state == st_idle);

	always_ff @(posedge in_clk, posedge in_rst) begin
		if (in_rst) begin
			state <= st_idle;
			bcd <= '0;
			bit_idx <= bit_idx_bits'(bin_bits - 1);
			digit_idx <= digit_idx_bits'(bcd_digits - 1);
		end else begin
			state <= state_next;
			bcd <= bcd_next;
			bit_idx <= bit_idx_next;
			digit_idx <= digit_idx_next;
		end
	end

	always_comb begin
		state_next = state;
		bcd_next = bcd;
		bit_idx_next = bit_idx;
		digit_idx_next = digit_idx;

		unique case (state)
			st_idle: begin
				if (start)
					state_next = st_load;
			end
			st_load: begin
				bcd_next = '0;
				bit_idx_next = bit_idx_bits'(bin_bits - 1);
				digit_idx_next = digit_idx_bits'(bcd_digits - 1);
				state_next = st_shift;
			end
			st_shift: begin
				// msb of the number enters at the bottom
				bcd_next.flat = {bcd.flat[bcd_bits-2:0], number[bit_idx]};
				if (bit_idx != '0)
					state_next = st_add;
				else
					state_next = st_idle;
			end
			st_add: begin
				// digit of 5 or more would overflow on the next shift
				if (bcd.digit[digit_idx] >= 4'd5)
					bcd_next.digit[digit_idx] = bcd.digit[digit_idx] + 4'd3;
				if (digit_idx != '0) begin
					digit_idx_next = digit_idx - 1'b1;
				end else begin
					digit_idx_next = digit_idx_bits'(bcd_digits - 1);
					state_next = st_next;
				end
			end
			st_next: begin
				bit_idx_next = bit_idx - 1'b1;
				state_next = st_shift;
			end
			default: state_next = st_idle;
		endcase
	end

	function automatic logic digits_ok(bcd_word_t w);
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < bcd_digits; i++) begin
			if (w.digit[i] > 4'd9)
				ok = 1'b0;
		end
		return ok;
	endfunction

	// result is proper bcd once idle
	a_digits_valid: assert property (@(posedge in_clk) disable iff (in_rst)
		finished |-> digits_ok(bcd));

	a_start_busy: assert property (@(posedge in_clk) disable iff (in_rst)
		(start && state == st_idle) |=> !finished);

endmodule

`default_nettype wire

// ==== hw/bcd_apb_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module bcd_apb_regs
	import bcd_pkg::*;
	import apb_map_pkg::*;
(
	input wire logic in_clk,
	input wire logic in_rst,
	input wire logic [apb_addr_bits-1:0] paddr,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [apb_data_bits-1:0] pwdata,
	output logic [apb_data_bits-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [bin_bits-1:0] number,
	output logic start,
	input wire bcd_word_t bcd,
	input wire logic finished
);

	logic is_number;
	logic is_ctrl;
	logic is_status;
	logic is_result;
	logic access;
	logic complete;
	logic addr_err;
	logic wr_busy;

	// address decode
	assign is_number = (paddr == reg_number);
	assign is_ctrl = (paddr == reg_ctrl);
	assign is_status = (paddr == reg_status);
	assign is_result = (paddr == reg_result);

	// unmapped offset, or a write to a read-only register
	assign addr_err = !(is_number || is_ctrl || is_status || is_result)
		|| (pwrite && (is_status || is_result));

	// number and ctrl writes stall until the converter is idle
	assign wr_busy = pwrite && (is_number || is_ctrl) && !finished;

	assign access = psel && penable;
	assign pready = !(access && wr_busy);
	assign pslverr = access && addr_err;
	assign complete = access && pready;

	// one cycle pulse, converter is idle whenever this fires
	assign start = complete && pwrite && is_ctrl && pwdata[ctrl_start_bit];

	always_ff @(posedge in_clk, posedge in_rst) begin
		if (in_rst) begin
			number <= '0;
		end else if (complete && pwrite && is_number) begin
			number <= pwdata[bin_bits-1:0];
		end
	end

	// read mux
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (paddr)
				reg_number: prdata[bin_bits-1:0] = number;
				reg_status: prdata[status_done_bit] = finished;
				reg_result: prdata[bcd_bits-1:0] = bcd.flat;
				default: prdata = '0;
			endcase
		end
	end

	a_penable_needs_psel: assert property (@(posedge in_clk) disable iff (in_rst)
		penable |-> psel);

endmodule

`default_nettype wire

// ==== hw/seg_display_scan.sv ====
`timescale 1ns/10ps
`default_nettype none

module seg_display_scan
	import bcd_pkg::*;
(
	input wire logic in_clk,
	input wire logic in_rst,
	input wire bcd_word_t bcd,
	output logic [6:0] seg,
	output logic [bcd_digits-1:0] digit_sel
);

	logic [scan_cnt_bits-1:0] div_cnt;
	logic step;
	logic [bcd_digits-1:0] sel_next;
	logic [3:0] cur_digit;

	assign step = (div_cnt == scan_cnt_bits'(scan_div - 1));

	// rotate ones, tens, hundreds
	assign sel_next = step ? {digit_sel[bcd_digits-2:0], digit_sel[bcd_digits-1]} : digit_sel;

	// digit for the select that becomes active next
	always_comb begin
		cur_digit = bcd.digit[0];
		for (int i = 1; i < bcd_digits; i++) begin
			if (sel_next[i])
				cur_digit = bcd.digit[i];
		end
	end

	// blank for mid-conversion values above 9
	function automatic logic [6:0] seg_of(logic [3:0] d);
		if (d <= 4'd9)
			return seg_pattern[d];
		return 7'h00;
	endfunction

	always_ff @(posedge in_clk, posedge in_rst) begin
		if (in_rst) begin
			div_cnt <= '0;
			digit_sel <= bcd_digits'(1);
			seg <= seg_pattern[0];
		end else begin
			div_cnt <= step ? '0 : div_cnt + 1'b1;
			digit_sel <= sel_next;
			seg <= seg_of(cur_digit);
		end
	end

	a_sel_onehot: assert property (@(posedge in_clk) disable iff (in_rst)
		$onehot(digit_sel));

endmodule

`default_nettype wire

// ==== hw/bcd_display_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module bcd_display_top
	import bcd_pkg::*;
	import apb_map_pkg::*;
(
	input wire logic in_clk,
	input wire logic in_rst,
	input wire logic [apb_addr_bits-1:0] paddr,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [apb_data_bits-1:0] pwdata,
	output logic [apb_data_bits-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [6:0] seg,
	output logic [bcd_digits-1:0] digit_sel
);

	logic [bin_bits-1:0] number;
	logic start;
	logic finished;
	bcd_word_t bcd;

	bcd_apb_regs i_regs (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.number(number),
		.start(start),
		.bcd(bcd),
		.finished(finished)
	);

	bcd_converter i_converter (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.start(start),
		.number(number),
		.bcd(bcd),
		.finished(finished)
	);

	seg_display_scan i_scan (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.bcd(bcd),
		.seg(seg),
		.digit_sel(digit_sel)
	);

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic in_clk,
	output logic in_rst
);

	localparam int rst_cycles = 8;

	initial begin
		in_clk = 1'b0;
		in_rst = 1'b1;
		repeat (rst_cycles) @(posedge in_clk);
		in_rst <= 1'b0;
	end

	// 20 ns period
	always #10 in_clk = ~in_clk;

endmodule

`default_nettype wire

// ==== tests/tb_bcd_display.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_bcd_display
	import bcd_pkg::*;
	import apb_map_pkg::*;
();

	localparam int n_random = 40;
	localparam int scan_rounds = 3;
	// 256 exhaustive plus random conversions and margin
	localparam int timeout_cycles = 300 * 60 + 2000;

	logic in_clk;
	logic in_rst;
	logic [apb_addr_bits-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [apb_data_bits-1:0] pwdata;
	logic [apb_data_bits-1:0] prdata;
	logic pready;
	logic pslverr;
	logic [6:0] seg;
	logic [bcd_digits-1:0] digit_sel;

	// display monitor control
	logic scan_en;
	logic [bcd_bits-1:0] scan_expect;
	logic [bcd_digits-1:0] scan_seen;
	int cycle_count;

	tb_clock_gen i_clock_gen (
		.in_clk(in_clk),
		.in_rst(in_rst)
	);

	bcd_display_top i_bcd_display_top (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.seg(seg),
		.digit_sel(digit_sel)
	);

	// hundreds, tens, ones by plain division
	function automatic logic [bcd_bits-1:0] to_bcd(input int unsigned n);
		logic [3:0] hundreds;
		logic [3:0] tens;
		logic [3:0] ones;
		hundreds = 4'(n / 100);
		tens = 4'((n / 10) % 10);
		ones = 4'(n % 10);
		return {hundreds, tens, ones};
	endfunction

	// active high in g f e d c b a order
	function automatic logic [6:0] seg_for(input logic [3:0] d);
		case (d)
			4'd0: return 7'b0111111;
			4'd1: return 7'b0000110;
			4'd2: return 7'b1011011;
			4'd3: return 7'b1001111;
			4'd4: return 7'b1100110;
			4'd5: return 7'b1101101;
			4'd6: return 7'b1111101;
			4'd7: return 7'b0000111;
			4'd8: return 7'b1111111;
			4'd9: return 7'b1101111;
			default: return 7'b0000000;
		endcase
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected) begin
			$display("Fail at %0t: %s, got 0x%0h, expected 0x%0h", $time, msg, actual, expected);
			$display("Verification failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// one APB transfer that waits out pready low in the access phase
	task automatic apb_transfer(input logic [apb_addr_bits-1:0] addr, input logic write,
		input logic [31:0] data, output logic [31:0] rdata, output logic err, output int waits);
		waits = 0;
		@(posedge in_clk);
		paddr <= addr;
		pwrite <= write;
		pwdata <= data;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge in_clk);
		penable <= 1'b1;
		@(negedge in_clk);
		while (!pready) begin
			waits++;
			@(negedge in_clk);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge in_clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic write_reg(input logic [apb_addr_bits-1:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic err;
		int waits;
		apb_transfer(addr, 1'b1, data, rdata, err, waits);
		check(err, 0, "unexpected pslverr on write");
	endtask

	task automatic read_reg(input logic [apb_addr_bits-1:0] addr, output logic [31:0] data);
		logic err;
		int waits;
		apb_transfer(addr, 1'b0, '0, data, err, waits);
		check(err, 0, "unexpected pslverr on read");
		check(waits, 0, "wait state on read");
	endtask

	task automatic wait_done();
		logic [31:0] status;
		status = '0;
		while (!status[status_done_bit])
			read_reg(reg_status, status);
	endtask

	task automatic convert(input int unsigned n, output logic [bcd_bits-1:0] result);
		logic [31:0] rdata;
		write_reg(reg_number, n);
		write_reg(reg_ctrl, 32'h1 << ctrl_start_bit);
		wait_done();
		read_reg(reg_result, rdata);
		check(rdata[31:bcd_bits], 0, "result upper bits not zero");
		result = rdata[bcd_bits-1:0];
	endtask

	// compares the scanned display against the expected digits
	always @(negedge in_clk) begin
		if (scan_en) begin
			check($onehot(digit_sel), 1, "digit_sel not one-hot");
			for (int k = 0; k < bcd_digits; k++) begin
				if (digit_sel[k]) begin
					check(seg, seg_for(scan_expect[4*k +: 4]), "segment pattern");
					scan_seen[k] = 1'b1;
				end
			end
		end
	end

	always @(posedge in_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("Verification failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		logic [31:0] rdata;
		logic [31:0] result_before;
		logic [bcd_bits-1:0] result;
		logic err;
		int waits;
		int unsigned num;
		int unsigned seed_val;

		seed_val = $urandom(71280);
		paddr <= '0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		pwdata <= '0;
		scan_en = 1'b0;
		scan_expect = '0;
		scan_seen = '0;
		cycle_count = 0;

		wait (in_rst == 1'b0);
		@(negedge in_clk);
		check(pready, 1, "pready after reset");
		check(pslverr, 0, "pslverr after reset");
		check(digit_sel, 1, "digit_sel after reset");
		check(seg, seg_for(4'd0), "segments after reset");
		read_reg(reg_status, rdata);
		check(rdata, 1, "status after reset");
		read_reg(reg_result, rdata);
		check(rdata, 0, "result after reset");
		read_reg(reg_number, rdata);
		check(rdata, 0, "number after reset");

		for (int n = 0; n < 256; n++) begin
			convert(n, result);
			for (int d = 0; d < bcd_digits; d++)
				check(result[4*d +: 4] <= 4'd9, 1, "digit above 9");
			check(result, to_bcd(n), "exhaustive conversion");
		end

		// number write right after start must stall until done
		write_reg(reg_number, 199);
		write_reg(reg_ctrl, 32'h1 << ctrl_start_bit);
		apb_transfer(reg_number, 1'b1, 58, rdata, err, waits);
		check(err, 0, "pslverr on stalled write");
		check(waits > 0, 1, "number write was not stalled");
		check(waits <= 40, 1, "stall longer than a conversion");
		read_reg(reg_status, rdata);
		check(rdata, 1, "done after stalled write");
		read_reg(reg_result, rdata);
		check(rdata, to_bcd(199), "conversion during stall");
		read_reg(reg_number, rdata);
		check(rdata, 58, "number after stalled write");

		// error responses
		read_reg(reg_result, result_before);
		apb_transfer(4'h2, 1'b0, '0, rdata, err, waits);
		check(err, 1, "read of unmapped 0x2");
		apb_transfer(4'h1, 1'b0, '0, rdata, err, waits);
		check(err, 1, "read of unmapped 0x1");
		apb_transfer(4'h6, 1'b1, 32'hAB, rdata, err, waits);
		check(err, 1, "write to unmapped 0x6");
		read_reg(reg_number, rdata);
		check(rdata, 58, "number after unmapped write");
		apb_transfer(reg_status, 1'b1, '0, rdata, err, waits);
		check(err, 1, "write to status");
		read_reg(reg_status, rdata);
		check(rdata, 1, "status after write attempt");
		apb_transfer(reg_result, 1'b1, 32'hFFF, rdata, err, waits);
		check(err, 1, "write to result");
		read_reg(reg_result, rdata);
		check(rdata, result_before, "result after write attempt");

		// random numbers and then the display scan
		repeat (n_random) begin
			num = $urandom_range(255, 0);
			convert(num, result);
			check(result, to_bcd(num), "random conversion");
			@(posedge in_clk);
			scan_expect = to_bcd(num);
			scan_seen = '0;
			scan_en = 1'b1;
			repeat (scan_rounds * scan_div * bcd_digits) @(posedge in_clk);
			scan_en = 1'b0;
			check(scan_seen, {bcd_digits{1'b1}}, "not every digit position shown");
		end

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/bcd_pkg.sv
hw/apb_map_pkg.sv
hw/bcd_converter.sv
hw/bcd_apb_regs.sv
hw/seg_display_scan.sv
hw/bcd_display_top.sv
tests/tb_clock_gen.sv
tests/tb_bcd_display.sv

// ==== Bender.yml ====
package:
  name: bcd_display

sources:
  - hw/bcd_pkg.sv
  - hw/apb_map_pkg.sv
  - hw/bcd_converter.sv
  - hw/bcd_apb_regs.sv
  - hw/seg_display_scan.sv
  - hw/bcd_display_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_bcd_display.sv
